/* src.f */
source/axi_mem_pkg.sv
source/axi_mem_if.sv
source/ready_enable_fifo.sv
source/axi_mem_reg.sv
source/axi_mem_sram.sv
source/axi_mem_subsys.sv
test/tb_axi_mem_subsys.sv

/* run_sim.sh */
#!/bin/sh
# Build and run the AXI memory subsystem testbench with Verilator.
# Run from anywhere; all paths are relative to the project root.

cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -Wno-fatal \
    --top-module tb_axi_mem_subsys -Mdir obj_dir -o tb_axi_mem_subsys -f src.f
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/tb_axi_mem_subsys > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "^Simulation completed successfully$" "$LOG"; then
    exit 0
fi
echo "Pass line not found in $LOG"
exit 1

/* test/tb_axi_mem_subsys.sv */
// Single-beat AXI only; reads target addresses whose writes have already been answered on B
`timescale 1ns/1ps

module tb_axi_mem_subsys;

    localparam int CLK_PERIOD = 4;
    localparam realtime DRIVE_DLY = 0.5;
    localparam int MEM_BYTES = axi_mem_pkg::MEM_WORDS * 4;

    // Transaction counts for each test phase
    localparam int N_BASIC = 32;
    localparam int N_STRB = 16;
    localparam int N_DECERR = 8;
    localparam int N_BURST = 32;
    localparam int N_READBACK = 8;
    localparam int N_TXN = 2 * N_BASIC + 2 * N_STRB + 3 * N_DECERR + 2 * N_BURST + N_READBACK;

    // Four times the transaction count, 20 cycles each
    localparam int WATCHDOG_NS = 4 * N_TXN * 20 * CLK_PERIOD;

    // Expected write response plus what the reference memory applies once B is seen
    typedef struct {
        axi_mem_pkg::id_t id;
        axi_mem_pkg::resp_t resp;
        axi_mem_pkg::addr_t addr;
        axi_mem_pkg::data_t data;
        axi_mem_pkg::strb_t strb;
    } wr_exp_t;

    typedef struct {
        axi_mem_pkg::id_t id;
        axi_mem_pkg::resp_t resp;
        axi_mem_pkg::data_t data;
    } rd_exp_t;

    logic clk;
    logic reset;
    logic awvalid;
    logic awready;
    axi_mem_pkg::id_t awid;
    axi_mem_pkg::addr_t awaddr;
    logic wvalid;
    logic wready;
    axi_mem_pkg::data_t wdata;
    axi_mem_pkg::strb_t wstrb;
    logic bvalid;
    logic bready;
    axi_mem_pkg::id_t bid;
    axi_mem_pkg::resp_t bresp;
    logic arvalid;
    logic arready;
    axi_mem_pkg::id_t arid;
    axi_mem_pkg::addr_t araddr;
    logic rvalid;
    logic rready;
    axi_mem_pkg::id_t rid;
    axi_mem_pkg::data_t rdata;
    axi_mem_pkg::resp_t rresp;

    integer seed = 32'h5552;
    logic burst_on = 1'b0;

    // Reference memory indexed by word, only written words exist
    axi_mem_pkg::data_t ref_mem [int];

    // Scoreboard queues in issue order
    wr_exp_t b_expect[$];
    rd_exp_t r_expect[$];
    wr_exp_t b_head;
    rd_exp_t r_head;

    axi_mem_pkg::addr_t basic_addr [N_BASIC];
    axi_mem_pkg::addr_t burst_wr_addr [N_BURST];
    axi_mem_pkg::data_t burst_wr_data [N_BURST];
    axi_mem_pkg::addr_t burst_rd_addr [N_BURST];

    axi_mem_subsys DUT
    (
        .clk(clk), .reset(reset),
        .awvalid(awvalid), .awready(awready), .awid(awid), .awaddr(awaddr),
        .wvalid(wvalid), .wready(wready), .wdata(wdata), .wstrb(wstrb),
        .bvalid(bvalid), .bready(bready), .bid(bid), .bresp(bresp),
        .arvalid(arvalid), .arready(arready), .arid(arid), .araddr(araddr),
        .rvalid(rvalid), .rready(rready), .rid(rid), .rdata(rdata), .rresp(rresp)
    );

    initial
    begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Reference rule: {data, resp} for a read, the resp half also serves writes
    // Bytes at 4096 and above decode as errors and read back as zero
    function automatic logic [axi_mem_pkg::DATA_W+1:0] expected_read(
        input axi_mem_pkg::addr_t addr);
        int word;
        word = int'(addr) / 4;
        if (int'(addr) >= MEM_BYTES)
            return {axi_mem_pkg::data_t'(0), axi_mem_pkg::RESP_DECERR};
        if (!ref_mem.exists(word))
            return {axi_mem_pkg::data_t'(0), axi_mem_pkg::RESP_OKAY};
        return {ref_mem[word], axi_mem_pkg::RESP_OKAY};
    endfunction

    // Merge the enabled bytes of an answered write into the reference memory
    function automatic void apply_write(input wr_exp_t t);
        int word;
        axi_mem_pkg::data_t merged;
        word = int'(t.addr) / 4;
        if (int'(t.addr) >= MEM_BYTES)
            return;
        merged = ref_mem.exists(word) ? ref_mem[word] : '0;
        for (int i = 0; i < axi_mem_pkg::STRB_W; i++)
        begin
            if (t.strb[i])
                merged[8*i +: 8] = t.data[8*i +: 8];
        end
        ref_mem[word] = merged;
    endfunction

    task automatic check_id(input string name, input axi_mem_pkg::id_t expected,
                            input axi_mem_pkg::id_t actual);
        if (actual !== expected)
        begin
            $display("Fail at %0.1f ns: %s expected %h, got %h", $realtime, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "ID mismatch");
        end
    endtask

    task automatic check_resp(input string name, input axi_mem_pkg::resp_t expected,
                              input axi_mem_pkg::resp_t actual);
        if (actual !== expected)
        begin
            $display("Fail at %0.1f ns: %s expected %h, got %h", $realtime, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Response code mismatch");
        end
    endtask

    task automatic check_data(input string name, input axi_mem_pkg::data_t expected,
                              input axi_mem_pkg::data_t actual);
        if (actual !== expected)
        begin
            $display("Fail at %0.1f ns: %s expected %h, got %h", $realtime, name, expected, actual);
            $display("Simulation failed");
            $fatal(1, "Data mismatch");
        end
    endtask

    task automatic check_low(input string name, input logic value);
        if (value !== 1'b0)
        begin
            $display("%s is not low around reset at %0.1f ns", name, $realtime);
            $display("Simulation failed");
            $fatal(1, "Reset state wrong");
        end
    endtask

    // All driving happens a short delay after the rising edge
    task automatic next_cycle();
        @(posedge clk);
        #(DRIVE_DLY);
    endtask

    // AW and W are offered together but each one drops on its own handshake
    task automatic write_txn(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::data_t data,
                             input axi_mem_pkg::strb_t strb, input axi_mem_pkg::id_t id);
        logic [axi_mem_pkg::DATA_W+1:0] ref_word;
        wr_exp_t t;
        logic aw_done;
        logic w_done;
        ref_word = expected_read(addr);
        t.id = id;
        t.resp = ref_word[1:0];
        t.addr = addr;
        t.data = data;
        t.strb = strb;
        b_expect.push_back(t);
        awvalid = 1'b1;
        awid = id;
        awaddr = addr;
        wvalid = 1'b1;
        wdata = data;
        wstrb = strb;
        aw_done = 1'b0;
        w_done = 1'b0;
        while (!(aw_done && w_done))
        begin
            @(posedge clk);
            if (awvalid && awready)
                aw_done = 1'b1;
            if (wvalid && wready)
                w_done = 1'b1;
            #(DRIVE_DLY);
            if (aw_done)
                awvalid = 1'b0;
            if (w_done)
                wvalid = 1'b0;
        end
    endtask

    task automatic read_txn(input axi_mem_pkg::addr_t addr, input axi_mem_pkg::id_t id);
        logic [axi_mem_pkg::DATA_W+1:0] ref_word;
        rd_exp_t t;
        logic ar_done;
        ref_word = expected_read(addr);
        t.id = id;
        t.data = ref_word[axi_mem_pkg::DATA_W+1:2];
        t.resp = ref_word[1:0];
        r_expect.push_back(t);
        arvalid = 1'b1;
        arid = id;
        araddr = addr;
        ar_done = 1'b0;
        while (!ar_done)
        begin
            @(posedge clk);
            ar_done = arready;
            #(DRIVE_DLY);
        end
        arvalid = 1'b0;
    endtask

    // Returns once every issued transaction has been answered
    task automatic wait_idle();
        while (b_expect.size() != 0 || r_expect.size() != 0)
            next_cycle();
    endtask

    // Scoreboard: each response handshake pops the oldest expectation
    always @(posedge clk)
    begin
        if (!reset && bvalid && bready)
        begin
            if (b_expect.size() == 0)
            begin
                $display("Write response arrived with nothing outstanding at %0.1f ns", $realtime);
                $display("Simulation failed");
                $fatal(1, "Extra write response");
            end
            else
            begin
                b_head = b_expect.pop_front();
                check_id("bid", b_head.id, bid);
                check_resp("bresp", b_head.resp, bresp);
                apply_write(b_head);
            end
        end
        if (!reset && rvalid && rready)
        begin
            if (r_expect.size() == 0)
            begin
                $display("Read response arrived with nothing outstanding at %0.1f ns", $realtime);
                $display("Simulation failed");
                $fatal(1, "Extra read response");
            end
            else
            begin
                r_head = r_expect.pop_front();
                check_id("rid", r_head.id, rid);
                check_resp("rresp", r_head.resp, rresp);
                check_data("rdata", r_head.data, rdata);
            end
        end
    end

    // Response back-pressure, random only while the burst runs
    initial
    begin
        bready = 1'b1;
        rready = 1'b1;
        forever
        begin
            next_cycle();
            if (burst_on)
            begin
                bready = 1'($random(seed));
                rready = 1'($random(seed));
            end
            else
            begin
                bready = 1'b1;
                rready = 1'b1;
            end
        end
    end

    initial
    begin
        #(WATCHDOG_NS);
        $display("Timeout: transactions did not complete within %0d ns", WATCHDOG_NS);
        $display("Simulation failed");
        $fatal(1, "Watchdog expired");
    end

    initial
    begin
        axi_mem_pkg::addr_t a;
        axi_mem_pkg::addr_t bad;
        int k;
        reset = 1'b1;
        awvalid = 1'b0;
        awid = '0;
        awaddr = '0;
        wvalid = 1'b0;
        wdata = '0;
        wstrb = '0;
        arvalid = 1'b0;
        arid = '0;
        araddr = '0;

        // Nothing may look valid or ready while reset is held
        repeat (16)
        begin
            next_cycle();
            check_low("bvalid", bvalid);
            check_low("rvalid", rvalid);
            check_low("awready", awready);
            check_low("wready", wready);
            check_low("arready", arready);
        end
        reset = 1'b0;
        repeat (3)
        begin
            next_cycle();
            check_low("bvalid", bvalid);
            check_low("rvalid", rvalid);
        end

        // Full-word write then read back, low address bits random since the SRAM ignores them
        for (int i = 0; i < N_BASIC; i++)
        begin
            a = axi_mem_pkg::addr_t'(({$random(seed)} % 512) * 4 + {$random(seed)} % 4);
            basic_addr[i] = a;
            write_txn(a, $random(seed), 4'hF, axi_mem_pkg::id_t'(i));
            wait_idle();
            read_txn(a, axi_mem_pkg::id_t'(i + 3));
            wait_idle();
        end

        // Partial strobes over words that already hold known data
        for (int i = 0; i < N_STRB; i++)
        begin
            k = {$random(seed)} % N_BASIC;
            write_txn(basic_addr[k], $random(seed), axi_mem_pkg::strb_t'($random(seed)),
                      axi_mem_pkg::id_t'(i));
            wait_idle();
            read_txn(basic_addr[k], axi_mem_pkg::id_t'(i + 5));
            wait_idle();
        end

        // Out-of-range write and read, then the in-range alias must be untouched
        for (int i = 0; i < N_DECERR; i++)
        begin
            k = {$random(seed)} % N_BASIC;
            bad = {4'(1 + {$random(seed)} % 15), basic_addr[k][11:0]};
            write_txn(bad, $random(seed), 4'hF, axi_mem_pkg::id_t'(i));
            wait_idle();
            read_txn(bad, axi_mem_pkg::id_t'(i + 1));
            wait_idle();
            read_txn(basic_addr[k], axi_mem_pkg::id_t'(i + 2));
            wait_idle();
        end

        // Burst writes go to the upper half, burst reads to words already settled
        for (int i = 0; i < N_BURST; i++)
        begin
            burst_wr_addr[i] = axi_mem_pkg::addr_t'(2048 + ({$random(seed)} % 512) * 4);
            burst_wr_data[i] = $random(seed);
            k = {$random(seed)} % N_BASIC;
            burst_rd_addr[i] = basic_addr[k];
        end
        burst_on = 1'b1;
        fork
            begin
                for (int i = 0; i < N_BURST; i++)
                    write_txn(burst_wr_addr[i], burst_wr_data[i], 4'hF, axi_mem_pkg::id_t'(i));
            end
            begin
                for (int j = 0; j < N_BURST; j++)
                    read_txn(burst_rd_addr[j], axi_mem_pkg::id_t'(j + 8));
            end
        join
        wait_idle();
        burst_on = 1'b0;

        // Words written during the burst must have landed
        for (int i = 0; i < N_READBACK; i++)
            read_txn(burst_wr_addr[N_BURST - 1 - i], axi_mem_pkg::id_t'(i));
        wait_idle();

        $display("Simulation completed successfully");
        $finish;
    end

endmodule

/* source/axi_mem_subsys.sv */
// One clock domain; port latency is REG_STAGES cycles each way plus one SRAM cycle when nothing stalls
`timescale 1ns/1ps

module axi_mem_subsys
(
    input  logic clk,
    input  logic reset,

    input  logic awvalid,
    output logic awready,
    input  axi_mem_pkg::id_t awid,
    input  axi_mem_pkg::addr_t awaddr,

    input  logic wvalid,
    output logic wready,
    input  axi_mem_pkg::data_t wdata,
    input  axi_mem_pkg::strb_t wstrb,

    output logic bvalid,
    input  logic bready,
    output axi_mem_pkg::id_t bid,
    output axi_mem_pkg::resp_t bresp,

    input  logic arvalid,
    output logic arready,
    input  axi_mem_pkg::id_t arid,
    input  axi_mem_pkg::addr_t araddr,

    output logic rvalid,
    input  logic rready,
    output axi_mem_pkg::id_t rid,
    output axi_mem_pkg::data_t rdata,
    output axi_mem_pkg::resp_t rresp
);

    // Port side and SRAM side of the pipeline
    axi_mem_if mem_in ();
    axi_mem_if mem_core ();

    assign mem_in.clk = clk;
    assign mem_in.reset = reset;
    assign mem_core.clk = clk;
    assign mem_core.reset = reset;

    // The top level acts as master on mem_in
    assign mem_in.awvalid = awvalid;
    assign mem_in.awid = awid;
    assign mem_in.awaddr = awaddr;
    assign mem_in.wvalid = wvalid;
    assign mem_in.wdata = wdata;
    assign mem_in.wstrb = wstrb;
    assign mem_in.bready = bready;
    assign mem_in.arvalid = arvalid;
    assign mem_in.arid = arid;
    assign mem_in.araddr = araddr;
    assign mem_in.rready = rready;

    // Ready and response signals come straight back out
    assign awready = mem_in.awready;
    assign wready = mem_in.wready;
    assign bvalid = mem_in.bvalid;
    assign bid = mem_in.bid;
    assign bresp = mem_in.bresp;
    assign arready = mem_in.arready;
    assign rvalid = mem_in.rvalid;
    assign rid = mem_in.rid;
    assign rdata = mem_in.rdata;
    assign rresp = mem_in.rresp;

    axi_mem_reg #(.N_REG_STAGES(axi_mem_pkg::REG_STAGES)) pipe
    (
        .mem_slave(mem_core),
        .mem_master(mem_in)
    );

    axi_mem_sram sram
    (
        .mem(mem_core)
    );

endmodule

/* source/axi_mem_sram.sv */
// Single-beat slave over 4 KiB; low two address bits are ignored and reads never see a same-edge write
`timescale 1ns/1ps

module axi_mem_sram
(
    axi_mem_if.to_master mem
);

    // Word storage, contents undefined until written
    axi_mem_pkg::data_t mem_array [axi_mem_pkg::MEM_WORDS];

    logic b_free;
    logic r_free;
    logic write_go;
    logic read_go;
    logic write_ok;
    logic read_ok;
    logic [$clog2(axi_mem_pkg::MEM_WORDS)-1:0] write_idx;
    logic [$clog2(axi_mem_pkg::MEM_WORDS)-1:0] read_idx;

    // True when the byte address falls inside the memory
    function automatic logic addr_in_range(input axi_mem_pkg::addr_t addr);
        return (32'(addr) >> 2) < axi_mem_pkg::MEM_WORDS;
    endfunction

    // Word index from a byte address, valid only for in-range addresses
    function automatic logic [$clog2(axi_mem_pkg::MEM_WORDS)-1:0] word_index(
        input axi_mem_pkg::addr_t addr);
        return addr[2 +: $clog2(axi_mem_pkg::MEM_WORDS)];
    endfunction

    assign write_ok = addr_in_range(mem.awaddr);
    assign read_ok = addr_in_range(mem.araddr);
    assign write_idx = word_index(mem.awaddr);
    assign read_idx = word_index(mem.araddr);

    // Each response path has one slot, free when empty or being taken this edge
    assign b_free = !mem.bvalid || mem.bready;
    assign r_free = !mem.rvalid || mem.rready;

    // A write needs its address and data together, so AW and W handshake on one edge
    assign write_go = mem.awvalid && mem.wvalid && b_free;
    assign mem.awready = write_go;
    assign mem.wready = write_go;

    assign read_go = mem.arvalid && r_free;
    assign mem.arready = read_go;

    // Byte-strobed write, skipped entirely on a decode error
    always_ff @(posedge mem.clk)
    begin
        if (write_go && write_ok)
        begin
            for (int i = 0; i < axi_mem_pkg::STRB_W; i++)
            begin
                if (mem.wstrb[i])
                    mem_array[write_idx][8*i +: 8] <= mem.wdata[8*i +: 8];
            end
        end
    end

    // Write response slot
    // A new write can load it on the same edge the old response leaves
    always_ff @(posedge mem.clk)
    begin
        if (mem.reset)
            mem.bvalid <= 1'b0;
        else if (write_go)
            mem.bvalid <= 1'b1;
        else if (mem.bready)
            mem.bvalid <= 1'b0;
    end

    always_ff @(posedge mem.clk)
    begin
        if (write_go)
        begin
            mem.bid <= mem.awid;
            mem.bresp <= write_ok ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_DECERR;
        end
    end

    // Read response slot, same scheme as the write side
    always_ff @(posedge mem.clk)
    begin
        if (mem.reset)
            mem.rvalid <= 1'b0;
        else if (read_go)
            mem.rvalid <= 1'b1;
        else if (mem.rready)
            mem.rvalid <= 1'b0;
    end

    // Out-of-range reads return zero data with a decode error
    always_ff @(posedge mem.clk)
    begin
        if (read_go)
        begin
            mem.rid <= mem.arid;
            mem.rdata <= read_ok ? mem_array[read_idx] : '0;
            mem.rresp <= read_ok ? axi_mem_pkg::RESP_OKAY : axi_mem_pkg::RESP_DECERR;
        end
    end

    // Responses stay put while the master stalls them
    b_held: assert property (@(posedge mem.clk) disable iff (mem.reset)
        mem.bvalid && !mem.bready |=> mem.bvalid && $stable(mem.bid) && $stable(mem.bresp));

    r_held: assert property (@(posedge mem.clk) disable iff (mem.reset)
        mem.rvalid && !mem.rready |=> mem.rvalid && $stable(mem.rid) && $stable(mem.rdata)
        && $stable(mem.rresp));

    // A write waiting here keeps its address and data until AW and W are taken as a pair
    aw_w_held: assert property (@(posedge mem.clk) disable iff (mem.reset)
        mem.awvalid && mem.wvalid && !mem.awready |=> mem.awvalid && mem.wvalid
        && $stable(mem.awid) && $stable(mem.awaddr)
        && $stable(mem.wdata) && $stable(mem.wstrb));

endmodule

/* source/axi_mem_reg.sv */
// Each stage adds one cycle per channel in its direction of travel; zero stages is a plain wire path
`timescale 1ns/1ps

module axi_mem_reg
#(
    // Number of registered stages, zero or more
    parameter int N_REG_STAGES = 1
)
(
    axi_mem_if.to_slave mem_slave,
    axi_mem_if.to_master mem_master
);

    // Stage N faces the master and stage 0 faces the slave
    // With no stages both ends meet on entry 0 and the path is combinational
    axi_mem_if mem_pipe[N_REG_STAGES+1] ();

    genvar s;

    // Master end enters at the top stage
    assign mem_pipe[N_REG_STAGES].awvalid = mem_master.awvalid;
    assign mem_pipe[N_REG_STAGES].awid = mem_master.awid;
    assign mem_pipe[N_REG_STAGES].awaddr = mem_master.awaddr;
    assign mem_pipe[N_REG_STAGES].wvalid = mem_master.wvalid;
    assign mem_pipe[N_REG_STAGES].wdata = mem_master.wdata;
    assign mem_pipe[N_REG_STAGES].wstrb = mem_master.wstrb;
    assign mem_pipe[N_REG_STAGES].bready = mem_master.bready;
    assign mem_pipe[N_REG_STAGES].arvalid = mem_master.arvalid;
    assign mem_pipe[N_REG_STAGES].arid = mem_master.arid;
    assign mem_pipe[N_REG_STAGES].araddr = mem_master.araddr;
    assign mem_pipe[N_REG_STAGES].rready = mem_master.rready;
    assign mem_master.awready = mem_pipe[N_REG_STAGES].awready;
    assign mem_master.wready = mem_pipe[N_REG_STAGES].wready;
    assign mem_master.bvalid = mem_pipe[N_REG_STAGES].bvalid;
    assign mem_master.bid = mem_pipe[N_REG_STAGES].bid;
    assign mem_master.bresp = mem_pipe[N_REG_STAGES].bresp;
    assign mem_master.arready = mem_pipe[N_REG_STAGES].arready;
    assign mem_master.rvalid = mem_pipe[N_REG_STAGES].rvalid;
    assign mem_master.rid = mem_pipe[N_REG_STAGES].rid;
    assign mem_master.rdata = mem_pipe[N_REG_STAGES].rdata;
    assign mem_master.rresp = mem_pipe[N_REG_STAGES].rresp;

    // Slave end leaves from stage 0
    assign mem_slave.awvalid = mem_pipe[0].awvalid;
    assign mem_slave.awid = mem_pipe[0].awid;
    assign mem_slave.awaddr = mem_pipe[0].awaddr;
    assign mem_slave.wvalid = mem_pipe[0].wvalid;
    assign mem_slave.wdata = mem_pipe[0].wdata;
    assign mem_slave.wstrb = mem_pipe[0].wstrb;
    assign mem_slave.bready = mem_pipe[0].bready;
    assign mem_slave.arvalid = mem_pipe[0].arvalid;
    assign mem_slave.arid = mem_pipe[0].arid;
    assign mem_slave.araddr = mem_pipe[0].araddr;
    assign mem_slave.rready = mem_pipe[0].rready;
    assign mem_pipe[0].awready = mem_slave.awready;
    assign mem_pipe[0].wready = mem_slave.wready;
    assign mem_pipe[0].bvalid = mem_slave.bvalid;
    assign mem_pipe[0].bid = mem_slave.bid;
    assign mem_pipe[0].bresp = mem_slave.bresp;
    assign mem_pipe[0].arready = mem_slave.arready;
    assign mem_pipe[0].rvalid = mem_slave.rvalid;
    assign mem_pipe[0].rid = mem_slave.rid;
    assign mem_pipe[0].rdata = mem_slave.rdata;
    assign mem_pipe[0].rresp = mem_slave.rresp;

    // One buffer per channel per stage
    // Requests move from stage s down to s-1, responses from s-1 up to s
    generate
        for (s = 1; s <= N_REG_STAGES; s = s + 1)
        begin : stage
            ready_enable_fifo #(.N_DATA_BITS(axi_mem_pkg::ID_W + axi_mem_pkg::ADDR_W)) aw
            (
                .clk(mem_slave.clk),
                .reset(mem_slave.reset),
                .enable_from_src(mem_pipe[s].awvalid),
                .data_from_src({mem_pipe[s].awid, mem_pipe[s].awaddr}),
                .ready_to_src(mem_pipe[s].awready),
                .enable_to_dst(mem_pipe[s-1].awvalid),
                .data_to_dst({mem_pipe[s-1].awid, mem_pipe[s-1].awaddr}),
                .ready_from_dst(mem_pipe[s-1].awready)
            );

            ready_enable_fifo #(.N_DATA_BITS(axi_mem_pkg::DATA_W + axi_mem_pkg::STRB_W)) w
            (
                .clk(mem_slave.clk),
                .reset(mem_slave.reset),
                .enable_from_src(mem_pipe[s].wvalid),
                .data_from_src({mem_pipe[s].wdata, mem_pipe[s].wstrb}),
                .ready_to_src(mem_pipe[s].wready),
                .enable_to_dst(mem_pipe[s-1].wvalid),
                .data_to_dst({mem_pipe[s-1].wdata, mem_pipe[s-1].wstrb}),
                .ready_from_dst(mem_pipe[s-1].wready)
            );

            ready_enable_fifo
                #(.N_DATA_BITS(axi_mem_pkg::ID_W + $bits(axi_mem_pkg::resp_t))) b
            (
                .clk(mem_slave.clk),
                .reset(mem_slave.reset),
                .enable_from_src(mem_pipe[s-1].bvalid),
                .data_from_src({mem_pipe[s-1].bid, mem_pipe[s-1].bresp}),
                .ready_to_src(mem_pipe[s-1].bready),
                .enable_to_dst(mem_pipe[s].bvalid),
                .data_to_dst({mem_pipe[s].bid, mem_pipe[s].bresp}),
                .ready_from_dst(mem_pipe[s].bready)
            );

            ready_enable_fifo #(.N_DATA_BITS(axi_mem_pkg::ID_W + axi_mem_pkg::ADDR_W)) ar
            (
                .clk(mem_slave.clk),
                .reset(mem_slave.reset),
                .enable_from_src(mem_pipe[s].arvalid),
                .data_from_src({mem_pipe[s].arid, mem_pipe[s].araddr}),
                .ready_to_src(mem_pipe[s].arready),
                .enable_to_dst(mem_pipe[s-1].arvalid),
                .data_to_dst({mem_pipe[s-1].arid, mem_pipe[s-1].araddr}),
                .ready_from_dst(mem_pipe[s-1].arready)
            );

            // R carries id, data and response as one packed word
            ready_enable_fifo #(.N_DATA_BITS(axi_mem_pkg::ID_W + axi_mem_pkg::DATA_W
                                             + $bits(axi_mem_pkg::resp_t))) r
            (
                .clk(mem_slave.clk),
                .reset(mem_slave.reset),
                .enable_from_src(mem_pipe[s-1].rvalid),
                .data_from_src({mem_pipe[s-1].rid, mem_pipe[s-1].rdata, mem_pipe[s-1].rresp}),
                .ready_to_src(mem_pipe[s-1].rready),
                .enable_to_dst(mem_pipe[s].rvalid),
                .data_to_dst({mem_pipe[s].rid, mem_pipe[s].rdata, mem_pipe[s].rresp}),
                .ready_from_dst(mem_pipe[s].rready)
            );
        end
    endgenerate

endmodule

/* source/ready_enable_fifo.sv */
// Two-entry elastic buffer; ready_to_src is registered and stays low during reset and one cycle after
`timescale 1ns/1ps

module ready_enable_fifo
#(
    // Width of the payload carried alongside enable
    parameter int N_DATA_BITS = 32
)
(
    input  logic clk,
    input  logic reset,

    input  logic enable_from_src,
    input  logic [N_DATA_BITS-1:0] data_from_src,
    output logic ready_to_src,

    output logic enable_to_dst,
    output logic [N_DATA_BITS-1:0] data_to_dst,
    input  logic ready_from_dst
);

    // Second entry, only filled while the output entry is stalled
    logic skid_valid;
    logic [N_DATA_BITS-1:0] skid_data;

    logic push;
    logic pop;
    logic load_out;
    logic [1:0] count;
    logic [1:0] count_next;

    assign push = enable_from_src && ready_to_src;
    assign pop = enable_to_dst && ready_from_dst;

    // The output entry may take a new item when it is empty or leaving this cycle
    assign load_out = !enable_to_dst || ready_from_dst;

    // Occupancy now and after this edge
    assign count = 2'(enable_to_dst) + 2'(skid_valid);
    assign count_next = count + 2'(push) - 2'(pop);

    // Control state
    // Ready is taken from the next occupancy so that it stays a plain flop output
    always_ff @(posedge clk)
    begin
        if (reset)
        begin
            enable_to_dst <= 1'b0;
            skid_valid <= 1'b0;
            ready_to_src <= 1'b0;
        end
        else
        begin
            ready_to_src <= (count_next != 2'd2);
            if (load_out)
            begin
                // The older skid entry goes first, otherwise the new item passes straight in
                enable_to_dst <= skid_valid || push;
                skid_valid <= 1'b0;
            end
            else if (push)
            begin
                skid_valid <= 1'b1;
            end
        end
    end

    // Payload registers
    always_ff @(posedge clk)
    begin
        if (load_out)
            data_to_dst <= skid_valid ? skid_data : data_from_src;
        if (!load_out && push)
            skid_data <= data_from_src;
    end

    // A held second entry is never overwritten before it moves to the output
    skid_held: assert property (@(posedge clk) disable iff (reset)
        skid_valid && !load_out |=> skid_valid && $stable(skid_data));

    // The destination sees a stable item for as long as it stalls
    out_held: assert property (@(posedge clk) disable iff (reset)
        enable_to_dst && !ready_from_dst |=> enable_to_dst && $stable(data_to_dst));

endmodule

/* source/axi_mem_if.sv */
// Single-beat AXI subset with no len, size, burst, lock, cache, prot or QoS; clk and reset live inside
`timescale 1ns/1ps

interface axi_mem_if;

    // Clock and synchronous active-high reset, driven by whoever owns the instance
    logic clk;
    logic reset;

    // Write address channel
    logic awvalid;
    logic awready;
    axi_mem_pkg::id_t awid;
    axi_mem_pkg::addr_t awaddr;

    // Write data channel, always a single beat
    logic wvalid;
    logic wready;
    axi_mem_pkg::data_t wdata;
    axi_mem_pkg::strb_t wstrb;

    // Write response channel
    logic bvalid;
    logic bready;
    axi_mem_pkg::id_t bid;
    axi_mem_pkg::resp_t bresp;

    // Read address channel
    logic arvalid;
    logic arready;
    axi_mem_pkg::id_t arid;
    axi_mem_pkg::addr_t araddr;

    // Read data channel, always a single beat
    logic rvalid;
    logic rready;
    axi_mem_pkg::id_t rid;
    axi_mem_pkg::data_t rdata;
    axi_mem_pkg::resp_t rresp;

    // Master side, connected toward a slave
    modport to_slave
    (
        input clk, reset,
        output awvalid, awid, awaddr, wvalid, wdata, wstrb, bready,
        output arvalid, arid, araddr, rready,
        input awready, wready, bvalid, bid, bresp, arready, rvalid, rid, rdata, rresp
    );

    // Slave side, connected toward a master
    modport to_master
    (
        input clk, reset,
        input awvalid, awid, awaddr, wvalid, wdata, wstrb, bready,
        input arvalid, arid, araddr, rready,
        output awready, wready, bvalid, bid, bresp, arready, rvalid, rid, rdata, rresp
    );

endinterface

/* source/axi_mem_pkg.sv */
// Single clock domain and single-beat AXI only; these widths size every port, buffer and memory
package axi_mem_pkg;

    // Byte address width of the AXI address channels
    localparam int ADDR_W = 16;

    // Data path width and its byte strobe width
    localparam int DATA_W = 32;
    localparam int STRB_W = DATA_W / 8;

    // Transaction ID width, echoed back unchanged in B and R
    localparam int ID_W = 4;

    // SRAM depth in data words, 4 KiB in total
    // Byte addresses at or above MEM_WORDS * 4 decode as errors
    localparam int MEM_WORDS = 1024;

    // Pipeline stages the top level puts between its ports and the SRAM
    localparam int REG_STAGES = 2;

    // Vector types for fields that carry a meaning
    typedef logic [ADDR_W-1:0] addr_t;
    typedef logic [DATA_W-1:0] data_t;
    typedef logic [STRB_W-1:0] strb_t;
    typedef logic [ID_W-1:0] id_t;
    typedef logic [1:0] resp_t;

    // AXI response codes used by the slave
    // EXOKAY and SLVERR are never produced
    localparam resp_t RESP_OKAY = 2'd0;
    localparam resp_t RESP_DECERR = 2'd3;

endpackage
